/* verilog/bramArrayPkg.sv */
`default_nettype none

package bramArrayPkg;

  // One block-RAM cell
  localparam int cellBits  = 32;
  localparam int cellBytes = 4;
  localparam int cellWords = 1024;

  // Cell grid
  localparam int numLanes = 3;    // Cells side by side
  localparam int numRows  = 4;    // Cells stacked in depth

  // One array word spans all lanes of a row
  localparam int rowBits  = 96;
  localparam int rowBytes = 12;

  // Index widths
  localparam int wordIdxBits = 10;
  localparam int rowIdxBits  = 30;  // Wide enough to see out-of-range rows
  localparam int addrBits    = 32;  // Port byte address

  // Lane 0 sits in the top 32 bits, lane 2 in the bottom 32 bits
  typedef logic [rowBits-1:0] rowDataT;

  // Byte enables, lane 0 in the top four bits
  typedef logic [rowBytes-1:0] rowStrbT;

  // Request on one array port
  typedef struct packed {
    logic                en;       // Access strobe for this cycle
    rowStrbT             wrEn;     // Any bit set makes it a write
    logic [addrBits-1:0] addr;     // Byte address
    rowDataT             wrData;
  } bramReqT;

  // Request on one cell port, already resolved to a word index
  typedef struct packed {
    logic                   en;
    logic [cellBytes-1:0]   wrEn;
    logic [wordIdxBits-1:0] wordIdx;
    logic [cellBits-1:0]    wrData;
  } cellReqT;

endpackage

`default_nettype wire

/* verilog/bramCell.sv */
`timescale 1ns/100ps
`default_nettype none

// Behavioral true dual-port cell, 32 bits by 1024 words, write-first on both ports
module bramCell (
  input  logic                              A_PS,
  input  logic                              reset,
  input  bramArrayPkg::cellReqT             reqA,
  input  bramArrayPkg::cellReqT             reqB,
  output logic [bramArrayPkg::cellBits-1:0] rdDataA,
  output logic [bramArrayPkg::cellBits-1:0] rdDataB
);

  import bramArrayPkg::*;

  // Storage starts out all zero
  logic [cellBits-1:0] mem [cellWords] = '{default: '0};

  logic [cellBits-1:0] oldWordA;     // Current contents at port A's word
  logic [cellBits-1:0] oldWordB;
  logic [cellBits-1:0] mergedA;      // Stored word after the byte merge
  logic [cellBits-1:0] mergedB;
  logic                writeA;
  logic                writeB;

  // Replace the enabled bytes of a word
  function automatic logic [cellBits-1:0] mergeBytes(
    input logic [cellBits-1:0]  oldWord,
    input logic [cellBits-1:0]  newWord,
    input logic [cellBytes-1:0] strb
  );
    logic [cellBits-1:0] result;
    result = oldWord;
    for (int b = 0; b < cellBytes; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign oldWordA = mem[reqA.wordIdx];
  assign oldWordB = mem[reqB.wordIdx];

  // With no byte enabled this is just the read word
  assign mergedA = mergeBytes(oldWordA, reqA.wrData, reqA.wrEn);
  assign mergedB = mergeBytes(oldWordB, reqB.wrData, reqB.wrEn);

  assign writeA = reqA.en && (|reqA.wrEn);
  assign writeB = reqB.en && (|reqB.wrEn);

  // Memory array, no write while in reset
  // Same-word accesses from both ports in one cycle are left undefined
  always_ff @(posedge A_PS) begin
    if (!reset) begin
      if (writeA) begin
        mem[reqA.wordIdx] <= mergedA;
      end
      if (writeB) begin
        mem[reqB.wordIdx] <= mergedB;
      end
    end
  end

  // Port A output register, loads only on an enabled edge
  always_ff @(posedge A_PS) begin
    if (reset) begin
      rdDataA <= '0;
    end else if (reqA.en) begin
      rdDataA <= mergedA;                // Write-first
    end
  end

  // Port B output register
  always_ff @(posedge A_PS) begin
    if (reset) begin
      rdDataB <= '0;
    end else if (reqB.en) begin
      rdDataB <= mergedB;                // Write-first
    end
  end

endmodule

`default_nettype wire

/* verilog/bramPortCtrl.sv */
`timescale 1ns/100ps
`default_nettype none

// Address resolution and read-back for one array port
module bramPortCtrl (
  input  logic                  A_PS,
  input  logic                  reset,
  input  bramArrayPkg::bramReqT req,
  output bramArrayPkg::cellReqT cellReq [bramArrayPkg::numRows][bramArrayPkg::numLanes],
  input  bramArrayPkg::rowDataT cellRdData [bramArrayPkg::numRows],
  output bramArrayPkg::rowDataT rdData
);

  import bramArrayPkg::*;

  logic [rowIdxBits-1:0]  wordAddr;      // Byte address in 32-bit words
  logic [rowIdxBits-1:0]  laneWordIdx;   // Word index down one lane column
  logic [rowIdxBits-1:0]  rowIdx;        // Raw row quotient, may exceed numRows
  logic [wordIdxBits-1:0] wordIdx;       // Word inside the selected cell
  logic                   inRange;
  logic [numRows-1:0]     rowSel;        // One-hot row strobe

  // State of the last enabled access, lines up with the cell output
  logic [rowIdxBits-1:0]  rowIdxQ;
  logic                   inRangeQ;

  // Address resolution
  assign wordAddr    = req.addr[addrBits-1:2];
  assign laneWordIdx = wordAddr / rowIdxBits'(numLanes);
  assign rowIdx      = laneWordIdx / rowIdxBits'(cellWords);
  assign wordIdx     = wordIdxBits'(laneWordIdx % rowIdxBits'(cellWords));
  assign inRange     = rowIdx < rowIdxBits'(numRows);

  always_comb begin
    for (int r = 0; r < numRows; r++) begin
      rowSel[r] = req.en && inRange && (rowIdx == rowIdxBits'(r));
    end
  end

  // Fan the request out to the grid
  // Only the selected row sees en and the byte enables
  always_comb begin
    for (int r = 0; r < numRows; r++) begin
      for (int l = 0; l < numLanes; l++) begin
        cellReq[r][l].en      = rowSel[r];
        cellReq[r][l].wordIdx = wordIdx;
        cellReq[r][l].wrData  = req.wrData[rowBits-1-cellBits*l -: cellBits];
        if (rowSel[r]) begin
          cellReq[r][l].wrEn = req.wrEn[rowBytes-1-cellBytes*l -: cellBytes];
        end else begin
          cellReq[r][l].wrEn = '0;
        end
      end
    end
  end

  // Row of the access, held until the next enabled cycle
  always_ff @(posedge A_PS) begin
    if (reset) begin
      rowIdxQ  <= '0;
      inRangeQ <= 1'b0;
    end else if (req.en) begin
      rowIdxQ  <= rowIdx;
      inRangeQ <= inRange;
    end
  end

  // Read multiplexer, zero after an out-of-range access
  always_comb begin
    rdData = '0;
    for (int r = 0; r < numRows; r++) begin
      if (inRangeQ && (rowIdxQ == rowIdxBits'(r))) begin
        rdData = cellRdData[r];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/tdpBramArray.sv */
`timescale 1ns/100ps
`default_nettype none

// True dual-port memory array, numRows by numLanes grid of block-RAM cells
module tdpBramArray (
  input  logic                  A_PS,
  input  logic                  reset,
  input  bramArrayPkg::bramReqT reqA,
  input  bramArrayPkg::bramReqT reqB,
  output bramArrayPkg::rowDataT rdDataA,
  output bramArrayPkg::rowDataT rdDataB
);

  import bramArrayPkg::*;

  // Per-cell requests from each port controller
  cellReqT cellReqA [numRows][numLanes];
  cellReqT cellReqB [numRows][numLanes];

  // Cell outputs gathered into one row word per row
  rowDataT cellRdDataA [numRows];
  rowDataT cellRdDataB [numRows];

  bramPortCtrl i_portCtrlA (
    .A_PS       (A_PS),
    .reset      (reset),
    .req        (reqA),
    .cellReq    (cellReqA),
    .cellRdData (cellRdDataA),
    .rdData     (rdDataA)
  );

  bramPortCtrl i_portCtrlB (
    .A_PS       (A_PS),
    .reset      (reset),
    .req        (reqB),
    .cellReq    (cellReqB),
    .cellRdData (cellRdDataB),
    .rdData     (rdDataB)
  );

  // Cell grid, lane 0 drives the top bits of each row word
  for (genvar r = 0; r < numRows; r++) begin : gRow
    for (genvar l = 0; l < numLanes; l++) begin : gLane
      bramCell i_bramCell (
        .A_PS    (A_PS),
        .reset   (reset),
        .reqA    (cellReqA[r][l]),
        .reqB    (cellReqB[r][l]),
        .rdDataA (cellRdDataA[r][rowBits-1-cellBits*l -: cellBits]),
        .rdDataB (cellRdDataB[r][rowBits-1-cellBits*l -: cellBits])
      );
    end
  end

endmodule

`default_nettype wire

/* tests/tdpBramArrayTable.svh */
localparam int numTests = 31;

// Column order is enA wrEnA addrA enB wrEnB addrB chkA chkB
// Byte address 12 * (row * 1024 + word) selects a row and word
testEntryT testTable [numTests] = '{
  '{1'b1, 12'h000, 32'h0000_0000, 1'b1, 12'h000, 32'h0000_3000, 1'b1, 1'b1},  // Unwritten
  '{1'b1, 12'h000, 32'h0000_BFF4, 1'b1, 12'h000, 32'h0000_9000, 1'b1, 1'b1},
  '{1'b1, 12'hFFF, 32'h0000_0000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},  // Row 0
  '{1'b1, 12'hFFF, 32'h0000_3000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},  // Row 1
  '{1'b1, 12'hFFF, 32'h0000_6000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},  // Row 2
  '{1'b1, 12'hFFF, 32'h0000_9000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},  // Row 3
  '{1'b1, 12'hFFF, 32'h0000_BFF4, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},  // Last word
  '{1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},
  '{1'b1, 12'h000, 32'h0000_3000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},
  '{1'b1, 12'h000, 32'h0000_6000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},
  '{1'b1, 12'h000, 32'h0000_9000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},
  '{1'b1, 12'h000, 32'h0000_BFF4, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},
  '{1'b0, 12'h000, 32'h0000_0000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b1},  // Hold
  '{1'b1, 12'h800, 32'h0000_0000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},  // Lane 0 top
  '{1'b1, 12'h00F, 32'h0000_0000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},  // Lane 2
  '{1'b1, 12'h0F0, 32'h0000_3000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},  // Lane 1
  '{1'b1, 12'h5A3, 32'h0000_6000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},
  '{1'b1, 12'h000, 32'h0000_0008, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b0},  // Alias of 0
  '{1'b1, 12'h000, 32'h0000_3000, 1'b1, 12'hFFF, 32'h0000_0018, 1'b1, 1'b1},
  '{1'b1, 12'h000, 32'h0000_0018, 1'b1, 12'h000, 32'h0000_6000, 1'b1, 1'b1},  // Cross port
  '{1'b1, 12'h00F, 32'h0000_9004, 1'b1, 12'h0C0, 32'h0000_000C, 1'b1, 1'b1},
  '{1'b1, 12'h000, 32'h0000_000C, 1'b1, 12'h000, 32'h0000_9000, 1'b1, 1'b1},
  '{1'b1, 12'hFFF, 32'h0000_6024, 1'b1, 12'hFFF, 32'h0000_6030, 1'b1, 1'b1},  // Same row
  '{1'b1, 12'h000, 32'h0000_6030, 1'b1, 12'h000, 32'h0000_6024, 1'b1, 1'b1},
  '{1'b1, 12'h000, 32'h0000_C000, 1'b1, 12'h000, 32'hFFFF_FFFC, 1'b1, 1'b1},  // Row 4 and up
  '{1'b1, 12'hFFF, 32'h0000_C000, 1'b1, 12'hFFF, 32'hFFFF_FFF0, 1'b1, 1'b1},
  '{1'b1, 12'h0F0, 32'h0000_C00C, 1'b1, 12'h000, 32'h0000_0000, 1'b1, 1'b1},
  '{1'b1, 12'h000, 32'h0000_0000, 1'b1, 12'h000, 32'h0000_000C, 1'b1, 1'b1},  // Read back
  '{1'b1, 12'h000, 32'h0000_3000, 1'b1, 12'h000, 32'h0000_3FF0, 1'b1, 1'b1},
  '{1'b1, 12'h000, 32'h0000_BFF4, 1'b1, 12'h000, 32'h0000_0018, 1'b1, 1'b1},
  '{1'b0, 12'h000, 32'h0000_0000, 1'b0, 12'h000, 32'h0000_0000, 1'b1, 1'b1}
};

/* tests/tdpBramArrayTb.sv */
`timescale 1ns/100ps
`default_nettype none

module tdpBramArrayTb;

  import bramArrayPkg::*;

  localparam int          clkPeriod   = 40;
  localparam int          resetCycles = 2;
  localparam int          driveDelay  = 2;   // Inputs change this long after the rising edge
  localparam logic [31:0] randSeed    = 32'h36ff6585;

  // One table row, write data comes from $urandom when the entry is applied
  typedef struct packed {
    logic                enA;
    rowStrbT             wrEnA;
    logic [addrBits-1:0] addrA;
    logic                enB;
    rowStrbT             wrEnB;
    logic [addrBits-1:0] addrB;
    logic                chkA;   // Compare rdDataA for this entry
    logic                chkB;
  } testEntryT;

  `include "tdpBramArrayTable.svh"

  localparam int watchdogTime = numTests * clkPeriod * 2 + resetCycles * clkPeriod;

  logic    A_PS;
  logic    reset;
  bramReqT reqA;
  bramReqT reqB;
  rowDataT rdDataA;
  rowDataT rdDataB;

  rowDataT refMem [int];   // Reference memory, key is row * cellWords + word index

  int testCount  = 0;
  int checkCount = 0;
  int errorCount = 0;

  tdpBramArray i_tdpBramArray (
    .A_PS    (A_PS),
    .reset   (reset),
    .reqA    (reqA),
    .reqB    (reqB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  initial begin
    A_PS = 1'b0;
    forever #(clkPeriod / 2) A_PS = ~A_PS;
  end

  // Compare one value with its expected value
  task automatic checkValue(input string sigName, input rowDataT actual, input rowDataT expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", sigName, actual, expected);
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testCount++;
    $display("%-10s %s", name, (errorCount == errorsBefore) ? "pass" : "FAIL");
  endtask

  function automatic rowDataT readModel(input int key);
    if (refMem.exists(key)) begin
      return refMem[key];
    end
    return '0;   // Memory starts at zero
  endfunction

  // Byte i of the row word follows strobe bit i
  function automatic rowDataT mergeRow(input rowDataT oldWord, input rowDataT newWord,
                                       input rowStrbT strb);
    rowDataT result;
    result = oldWord;
    for (int i = 0; i < rowBytes; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = newWord[8*i +: 8];
      end
    end
    return result;
  endfunction

  // One port access on the reference model, expRd holds through idle cycles
  task automatic modelAccess(input logic en, input rowStrbT wrEn, input logic [addrBits-1:0] addr,
                             input rowDataT wrData, inout rowDataT expRd);
    logic [addrBits-1:0] laneWordIdx;
    logic [addrBits-1:0] rowIdx;
    logic [addrBits-1:0] wordIdx;
    int                  key;
    rowDataT             merged;
    if (en) begin
      laneWordIdx = (addr >> 2) / numLanes;
      rowIdx      = laneWordIdx / cellWords;
      wordIdx     = laneWordIdx % cellWords;
      if (rowIdx < numRows) begin
        key    = int'(rowIdx) * cellWords + int'(wordIdx);
        merged = mergeRow(readModel(key), wrData, wrEn);
        if (|wrEn) begin
          refMem[key] = merged;
        end
        expRd = merged;   // Write-first
      end else begin
        expRd = '0;   // Out of range reads zero and writes nothing
      end
    end
  endtask

  initial begin : stimulus
    testEntryT entry;
    rowDataT   dataA;
    rowDataT   dataB;
    rowDataT   expA;
    rowDataT   expB;
    int        errorsBefore;
    void'($urandom(randSeed));
    reset = 1'b1;
    reqA  = '0;
    reqB  = '0;
    expA  = '0;
    expB  = '0;
    repeat (resetCycles) @(posedge A_PS);
    #driveDelay;
    reset = 1'b0;

    // Outputs cleared by reset
    errorsBefore = errorCount;
    checkValue("rdDataA", rdDataA, expA);
    checkValue("rdDataB", rdDataB, expB);
    reportTest("reset", errorsBefore);

    // Entry k is checked one edge after it was sampled
    for (int k = 0; k <= numTests; k++) begin
      @(posedge A_PS);
      #driveDelay;
      if (k > 0) begin
        errorsBefore = errorCount;
        if (testTable[k-1].chkA) begin
          checkValue("rdDataA", rdDataA, expA);
        end
        if (testTable[k-1].chkB) begin
          checkValue("rdDataB", rdDataB, expB);
        end
        reportTest($sformatf("entry %0d", k - 1), errorsBefore);
      end
      if (k < numTests) begin
        entry       = testTable[k];
        dataA       = {$urandom(), $urandom(), $urandom()};
        dataB       = {$urandom(), $urandom(), $urandom()};
        reqA.en     = entry.enA;
        reqA.wrEn   = entry.wrEnA;
        reqA.addr   = entry.addrA;
        reqA.wrData = dataA;
        reqB.en     = entry.enB;
        reqB.wrEn   = entry.wrEnB;
        reqB.addr   = entry.addrB;
        reqB.wrData = dataB;
        modelAccess(entry.enA, entry.wrEnA, entry.addrA, dataA, expA);
        modelAccess(entry.enB, entry.wrEnB, entry.addrB, dataB, expB);
      end else begin
        reqA = '0;
        reqB = '0;
      end
    end

    $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdogTime);
    $display("Timeout: the table did not finish within %0d ns", watchdogTime);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+tests
verilog/bramArrayPkg.sv
verilog/bramCell.sv
verilog/bramPortCtrl.sv
verilog/tdpBramArray.sv
tests/tdpBramArrayTb.sv

/* Makefile */
# Verilator build and run of the dual-port memory array testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tdpBramArrayTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(OBJDIR)/V$(TOP): $(FILELIST) $(shell sed -n 's/^\([^+].*\)$$/\1/p' $(FILELIST)) \
                   tests/tdpBramArrayTable.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The run passes only if the pass message shows up in the output
test: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
